/* build.f */
+incdir+hdl
hdl/mmuPkg.sv
hdl/tlbArray.sv
hdl/tableWalk.sv
hdl/accessCheck.sv
hdl/faultRegs.sv
hdl/mmu.sv
dv/tbMemory.sv
dv/mmuTb.sv

/* dv/mmuTb.sv */
`timescale 1ns/1ps
`include "mmu_consts.svh"
`default_nettype none

module mmuTb;

  import mmuPkg::*;

  localparam int READY_TIMEOUT = 50;
  localparam logic [17:0] TBASE = 18'h00004;
  // Domains 0 client, 1 manager, 2 no access, 3 reserved, 4 client
  localparam logic [31:0] DOMAIN_ACCESS = 32'h0000_018D;
  // Coarse tables at 0x14000 and 0x14400
  localparam logic [21:0] COARSE_A = 22'h00050;
  localparam logic [21:0] COARSE_B = 22'h00051;
  // Offset masks for random data words
  localparam logic [31:0] SECT_OFF = 32'h000F_FFFC;
  localparam logic [31:0] PAGE_OFF = 32'h0000_0FFC;
  localparam logic [31:0] ANY_OFF = 32'h7FFF_FFFC;
  localparam logic [31:0] NO_OFF = 32'h0;
  // Mode is {mmuOn, flush first}
  localparam logic [1:0] OFF = 2'b00;
  localparam logic [1:0] ON = 2'b10;
  localparam logic [1:0] ON_FLUSH = 2'b11;
  // Access is {write, supervisor, word, data}
  localparam logic [3:0] USER_RD = 4'b0011;
  localparam logic [3:0] USER_WR = 4'b1011;
  localparam logic [3:0] USER_IF = 4'b0010;
  localparam logic [3:0] USER_RDB = 4'b0001;
  localparam logic [3:0] SUP_RD = 4'b0111;
  localparam logic [3:0] SUP_WR = 4'b1111;
  localparam logic [3:0] SUP_IF = 4'b0110;

  typedef struct packed {
    logic [1:0]  mode;
    logic [31:0] vaBase;
    logic [31:0] paBase;
    logic [31:0] offMask;
    logic [3:0]  access;
    faultCode    expFault;
    logic [3:0]  expDomain;
    logic [1:0]  expReads;
  } stimRow;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] control;
  logic [31:0] domainAccess;
  logic [17:0] tBase;
  logic        tlbFlush;
  logic        cpuReq;
  logic        cpuWrite;
  logic [31:0] cpuAddr;
  logic        wordAccess;
  logic        supMode;
  logic        dataAccess;
  logic        busReady;
  logic [31:0] busRData;
  logic        cpuReady;
  logic        busReq;
  logic        busWrite;
  logic [31:0] busAddr;
  logic        prefetchAbort;
  logic        dataAbort;
  logic [31:0] fsr;
  logic [31:0] far;
  int          descReads;

  stimRow rows[$];
  integer seed;
  int     errors;
  int     rowsRun;
  int     rowsBad;
  logic   timedOut;

  always #50 clk = ~clk;

  mmu dut0 (
    .clk(clk), .rst(rst), .control(control), .domainAccess(domainAccess),
    .tBase(tBase), .tlbFlush(tlbFlush), .cpuReq(cpuReq), .cpuWrite(cpuWrite),
    .cpuAddr(cpuAddr), .wordAccess(wordAccess), .supMode(supMode),
    .dataAccess(dataAccess), .busReady(busReady), .busRData(busRData),
    .cpuReady(cpuReady), .busReq(busReq), .busWrite(busWrite), .busAddr(busAddr),
    .prefetchAbort(prefetchAbort), .dataAbort(dataAbort), .fsr(fsr), .far(far)
  );

  tbMemory mem0 (
    .clk(clk), .rst(rst), .busReq(busReq), .busWrite(busWrite), .busAddr(busAddr),
    .busReady(busReady), .busRData(busRData), .descReads(descReads)
  );

  // First-level entry address for a 1 MB index
  function automatic logic [31:0] l1Addr(input logic [11:0] idx);
    return {TBASE, idx, 2'b00};
  endfunction

  // Coarse table entry address
  function automatic logic [31:0] l2Addr(input logic [21:0] base, input logic [7:0] idx);
    return {base, idx, 2'b00};
  endfunction

  function automatic logic [31:0] sectionDesc(input logic [11:0] pa, input logic [3:0] dom,
                                              input apType ap);
    return {pa, 8'h00, ap, 1'b0, dom, 1'b0, 2'b00, `MMU_L1_TYPE_SECTION};
  endfunction

  function automatic logic [31:0] coarseDesc(input logic [21:0] base, input logic [3:0] dom);
    return {base, 1'b0, dom, 1'b0, 2'b00, `MMU_L1_TYPE_COARSE};
  endfunction

  // Same AP in all four subpage fields
  function automatic logic [31:0] pageDesc(input logic [19:0] frame, input apType ap);
    return {frame, ap, ap, ap, ap, 2'b00, `MMU_L2_TYPE_SMALL};
  endfunction

  task automatic loadTables();
    // Sections 0x001 to 0x007 map to 0x200 upward
    mem0.writeWord(l1Addr(12'h001), sectionDesc(12'h200, 4'd1, AP_NONE));
    mem0.writeWord(l1Addr(12'h002), sectionDesc(12'h201, 4'd0, AP_FULL));
    mem0.writeWord(l1Addr(12'h003), sectionDesc(12'h202, 4'd0, AP_SUPER));
    mem0.writeWord(l1Addr(12'h004), sectionDesc(12'h203, 4'd0, AP_USER_RO));
    mem0.writeWord(l1Addr(12'h005), sectionDesc(12'h204, 4'd0, AP_NONE));
    mem0.writeWord(l1Addr(12'h006), sectionDesc(12'h205, 4'd2, AP_FULL));
    mem0.writeWord(l1Addr(12'h007), sectionDesc(12'h206, 4'd3, AP_FULL));
    mem0.writeWord(l1Addr(12'h008), coarseDesc(COARSE_A, 4'd4));
    mem0.writeWord(l1Addr(12'h009), coarseDesc(COARSE_B, 4'd2));
    // Unmapped section
    mem0.writeWord(l1Addr(12'h00A), 32'h0);
    mem0.writeWord(l2Addr(COARSE_A, 8'h00), pageDesc(20'h30000, AP_FULL));
    mem0.writeWord(l2Addr(COARSE_A, 8'h01), pageDesc(20'h30001, AP_USER_RO));
    mem0.writeWord(l2Addr(COARSE_A, 8'h02), pageDesc(20'h30002, AP_SUPER));
    // Unmapped small page
    mem0.writeWord(l2Addr(COARSE_A, 8'h03), 32'h0);
    mem0.writeWord(l2Addr(COARSE_B, 8'h00), pageDesc(20'h30010, AP_FULL));
  endtask

  task automatic addRow(input logic [1:0] mode, input logic [31:0] va, input logic [31:0] pa,
                        input logic [31:0] offMask, input logic [3:0] access,
                        input faultCode fault, input logic [3:0] dom, input logic [1:0] reads);
    stimRow r;
    r = '{mode, va, pa, offMask, access, fault, dom, reads};
    rows.push_back(r);
  endtask

  task automatic buildRows();
    // Bus follows the CPU with translation off
    addRow(OFF, 32'h8000_0000, 32'h8000_0000, ANY_OFF, USER_RD, NO_FAULT, 4'd0, 2'd0);
    addRow(OFF, 32'h8000_0000, 32'h8000_0000, ANY_OFF, USER_WR, NO_FAULT, 4'd0, 2'd0);
    addRow(OFF, 32'h8000_0000, 32'h8000_0000, ANY_OFF, SUP_IF, NO_FAULT, 4'd0, 2'd0);
    // Manager domain ignores AP
    addRow(ON, 32'h0010_0000, 32'h2000_0000, SECT_OFF, USER_RD, NO_FAULT, 4'd1, 2'd1);
    addRow(ON, 32'h0010_0000, 32'h2000_0000, SECT_OFF, USER_WR, NO_FAULT, 4'd1, 2'd0);
    addRow(ON, 32'h0020_0000, 32'h2010_0000, SECT_OFF, USER_RD, NO_FAULT, 4'd0, 2'd1);
    addRow(ON, 32'h0020_0000, 32'h2010_0000, SECT_OFF, USER_WR, NO_FAULT, 4'd0, 2'd0);
    addRow(ON, 32'h0020_0000, 32'h2010_0000, SECT_OFF, SUP_IF, NO_FAULT, 4'd0, 2'd0);
    // Supervisor only
    addRow(ON, 32'h0030_0000, 32'h2020_0000, SECT_OFF, SUP_RD, NO_FAULT, 4'd0, 2'd1);
    addRow(ON, 32'h0030_0000, 32'h2020_0000, SECT_OFF, SUP_WR, NO_FAULT, 4'd0, 2'd0);
    addRow(ON, 32'h0030_0000, 32'h0, SECT_OFF, USER_RD, SECT_PERM, 4'd0, 2'd0);
    addRow(ON, 32'h0030_0000, 32'h0, SECT_OFF, USER_WR, SECT_PERM, 4'd0, 2'd0);
    // User read only
    addRow(ON, 32'h0040_0000, 32'h2030_0000, SECT_OFF, USER_RD, NO_FAULT, 4'd0, 2'd1);
    addRow(ON, 32'h0040_0000, 32'h0, SECT_OFF, USER_WR, SECT_PERM, 4'd0, 2'd0);
    addRow(ON, 32'h0040_0000, 32'h2030_0000, SECT_OFF, SUP_WR, NO_FAULT, 4'd0, 2'd0);
    // Client with no access walks once and then faults
    addRow(ON, 32'h0050_0000, 32'h0, SECT_OFF, SUP_RD, SECT_PERM, 4'd0, 2'd1);
    addRow(ON, 32'h0050_0000, 32'h0, SECT_OFF, USER_WR, SECT_PERM, 4'd0, 2'd0);
    // Domain fields 00 and 10
    addRow(ON, 32'h0060_0000, 32'h0, SECT_OFF, SUP_RD, SECT_DOMAIN, 4'd2, 2'd1);
    addRow(ON, 32'h0060_0000, 32'h0, SECT_OFF, USER_IF, SECT_DOMAIN, 4'd2, 2'd0);
    addRow(ON, 32'h0070_0000, 32'h0, SECT_OFF, SUP_RD, SECT_DOMAIN, 4'd3, 2'd1);
    // Translation faults are never cached
    addRow(ON, 32'h00A0_0000, 32'h0, SECT_OFF, USER_RD, SECT_TRANS, 4'd0, 2'd1);
    addRow(ON, 32'h00A0_0000, 32'h0, SECT_OFF, USER_IF, SECT_TRANS, 4'd0, 2'd1);
    // Small pages under domain 4
    addRow(ON, 32'h0080_0000, 32'h3000_0000, PAGE_OFF, USER_RD, NO_FAULT, 4'd4, 2'd2);
    addRow(ON, 32'h0080_0000, 32'h3000_0000, PAGE_OFF, USER_WR, NO_FAULT, 4'd4, 2'd0);
    addRow(ON, 32'h0080_1000, 32'h3000_1000, PAGE_OFF, USER_RD, NO_FAULT, 4'd4, 2'd2);
    addRow(ON, 32'h0080_1000, 32'h0, PAGE_OFF, USER_WR, PAGE_PERM, 4'd4, 2'd0);
    addRow(ON, 32'h0080_1000, 32'h3000_1000, PAGE_OFF, SUP_WR, NO_FAULT, 4'd4, 2'd0);
    addRow(ON, 32'h0080_2000, 32'h0, PAGE_OFF, USER_RD, PAGE_PERM, 4'd4, 2'd2);
    addRow(ON, 32'h0080_2000, 32'h3000_2000, PAGE_OFF, SUP_RD, NO_FAULT, 4'd4, 2'd0);
    addRow(ON, 32'h0080_3000, 32'h0, PAGE_OFF, USER_RD, PAGE_TRANS, 4'd4, 2'd2);
    addRow(ON, 32'h0080_3000, 32'h0, PAGE_OFF, USER_IF, PAGE_TRANS, 4'd4, 2'd2);
    addRow(ON, 32'h0090_0000, 32'h0, PAGE_OFF, SUP_RD, PAGE_DOMAIN, 4'd2, 2'd2);
    addRow(ON, 32'h0090_0000, 32'h0, PAGE_OFF, USER_WR, PAGE_DOMAIN, 4'd2, 2'd0);
    // Misaligned word accesses on cached translations abort while byte accesses pass
    addRow(ON, 32'h0020_0002, 32'h0, NO_OFF, USER_RD, ALIGN, 4'd0, 2'd0);
    addRow(ON, 32'h0080_0001, 32'h0, NO_OFF, SUP_WR, ALIGN, 4'd4, 2'd0);
    addRow(ON, 32'h0020_0003, 32'h2010_0003, NO_OFF, USER_RDB, NO_FAULT, 4'd0, 2'd0);
    // Translation off bypasses a section still held in the TLB
    addRow(OFF, 32'h0020_0000, 32'h0020_0000, SECT_OFF, USER_WR, NO_FAULT, 4'd0, 2'd0);
    // Flush forces fresh walks
    addRow(ON_FLUSH, 32'h0020_0000, 32'h2010_0000, SECT_OFF, USER_RD, NO_FAULT, 4'd0, 2'd1);
    addRow(ON, 32'h0020_0000, 32'h2010_0000, SECT_OFF, USER_RD, NO_FAULT, 4'd0, 2'd0);
    addRow(ON_FLUSH, 32'h0080_0000, 32'h3000_0000, PAGE_OFF, USER_RD, NO_FAULT, 4'd4, 2'd2);
  endtask

  task automatic checkValue(input string what, input logic [31:0] got,
                            input logic [31:0] expected);
    if (got !== expected) begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, expected);
      errors++;
    end
  endtask

  // Waits for cpuReady on falling edges
  task automatic waitReady(output logic ok);
    int cycles;
    ok = 1'b0;
    cycles = 0;
    while (!ok && cycles < READY_TIMEOUT) begin
      @(negedge clk);
      if (cpuReady) begin
        ok = 1'b1;
      end
      cycles++;
    end
  endtask

  task automatic runRow(input stimRow r, input int idx);
    logic [31:0] off;
    logic [31:0] va;
    logic [31:0] pa;
    int          readsBefore;
    int          errsBefore;
    logic        ok;
    off = $random(seed) & r.offMask;
    va = r.vaBase | off;
    pa = r.paBase | off;
    errsBefore = errors;
    @(negedge clk);
    readsBefore = descReads;
    @(posedge clk);
    if (r.mode[0]) begin
      tlbFlush <= 1'b1;
      @(posedge clk);
      tlbFlush <= 1'b0;
    end
    control    <= {31'b0, r.mode[1]};
    cpuAddr    <= va;
    cpuWrite   <= r.access[3];
    supMode    <= r.access[2];
    wordAccess <= r.access[1];
    dataAccess <= r.access[0];
    cpuReq     <= 1'b1;
    waitReady(ok);
    if (!ok) begin
      timedOut = 1'b1;
      $display("Row %0d: cpuReady did not rise within %0d cycles", idx, READY_TIMEOUT);
    end else begin
      checkValue("descriptor reads", 32'(descReads - readsBefore), 32'(r.expReads));
      if (r.expFault == NO_FAULT) begin
        checkValue("busReq", 32'(busReq), 32'd1);
        checkValue("busAddr", busAddr, pa);
        checkValue("busWrite", 32'(busWrite), 32'(r.access[3]));
        checkValue("prefetchAbort", 32'(prefetchAbort), 32'd0);
        checkValue("dataAbort", 32'(dataAbort), 32'd0);
      end else begin
        // Aborted access never reaches the bus
        checkValue("busReq", 32'(busReq), 32'd0);
        checkValue("prefetchAbort", 32'(prefetchAbort), 32'(!r.access[0]));
        checkValue("dataAbort", 32'(dataAbort), 32'(r.access[0]));
      end
      @(posedge clk);
      cpuReq <= 1'b0;
      if (r.expFault != NO_FAULT) begin
        // FSR and FAR readable one cycle after the abort
        @(negedge clk);
        checkValue("fsr", fsr, {24'b0, r.expDomain, r.expFault});
        checkValue("far", far, va);
      end
      rowsRun++;
      if (errors != errsBefore) begin
        rowsBad++;
      end
      $display("Row %0d va %h %s: %s", idx, va, r.expFault.name(),
               (errors == errsBefore) ? "ok" : "mismatch");
    end
  endtask

  initial begin
    seed = 75;
    errors = 0;
    rowsRun = 0;
    rowsBad = 0;
    timedOut = 1'b0;
    rst = 1'b1;
    control = 32'h1;
    domainAccess = DOMAIN_ACCESS;
    tBase = TBASE;
    tlbFlush = 1'b0;
    cpuReq = 1'b0;
    cpuWrite = 1'b0;
    cpuAddr = 32'h0;
    wordAccess = 1'b0;
    supMode = 1'b0;
    dataAccess = 1'b0;
    loadTables();
    buildRows();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    // Quiet outputs once out of reset with translation on
    @(negedge clk);
    checkValue("busReq after reset", 32'(busReq), 32'd0);
    checkValue("cpuReady after reset", 32'(cpuReady), 32'd0);
    checkValue("aborts after reset", 32'({prefetchAbort, dataAbort}), 32'd0);
    for (int i = 0; i < rows.size(); i++) begin
      runRow(rows[i], i);
      if (timedOut) begin
        break;
      end
    end
    $display("Rows run %0d of %0d, rows with mismatches %0d, check errors %0d",
             rowsRun, rows.size(), rowsBad, errors);
    if (errors == 0 && !timedOut) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/tbMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module tbMemory #(
  parameter logic [31:0] TABLE_LO = 32'h0001_0000,
  parameter logic [31:0] TABLE_HI = 32'h0001_8000
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        busReq,
  input  logic        busWrite,
  input  logic [31:0] busAddr,
  output logic        busReady,
  output logic [31:0] busRData,
  output int          descReads
);

  // Sparse word store keyed by word address
  logic [31:0] words [logic [31:0]];

  // Preload hook for page tables
  task automatic writeWord(input logic [31:0] addr, input logic [31:0] data);
    words[{addr[31:2], 2'b00}] = data;
  endtask

  // Unwritten words return a pattern of their address
  // Low two bits stay zero so stray descriptors decode as faults
  function automatic logic [31:0] readWord(input logic [31:0] addr);
    logic [31:0] key;
    key = {addr[31:2], 2'b00};
    if (words.exists(key)) begin
      return words[key];
    end
    return (key ^ 32'h5A5A_5A5A) & 32'hFFFF_FFFC;
  endfunction

  // One-cycle answer, ready pulses for a single cycle
  always @(posedge clk) begin
    if (rst) begin
      busReady  <= 1'b0;
      busRData  <= '0;
      descReads <= 0;
    end else if (busReq && !busReady) begin
      busReady <= 1'b1;
      busRData <= busWrite ? 32'h0 : readWord(busAddr);
      // Reads inside the table window are descriptor fetches
      if (!busWrite && busAddr >= TABLE_LO && busAddr < TABLE_HI) begin
        descReads <= descReads + 1;
      end
    end else begin
      busReady <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hdl/accessCheck.sv */
`timescale 1ns/1ps
`default_nettype none

module accessCheck (
  input  logic [1:0]       cpuAddr,
  input  logic             wordAccess,
  input  logic             supMode,
  input  logic             cpuWrite,
  input  logic             hit,
  input  mmuPkg::tlbEntry  hitEntry,
  input  logic [31:0]      domainAccess,
  output logic             checkFault,
  output mmuPkg::faultCode checkCode
);

  import mmuPkg::*;

  logic [1:0] domainField;
  logic       misaligned;
  logic       domainFault;
  logic       permFault;

  // Two bits of domainAccess per domain
  assign domainField = domainAccess[{hitEntry.domain, 1'b0} +: 2];

  // Word accesses need both low address bits clear
  assign misaligned = wordAccess && (cpuAddr != 2'b00);

  // Domain and permission decode
  always_comb begin
    domainFault = 1'b0;
    permFault   = 1'b0;
    case (domainField)
      // Manager, no permission check
      2'b11: begin
        domainFault = 1'b0;
      end
      // Client, AP decides
      2'b01: begin
        case (hitEntry.ap)
          AP_NONE:    permFault = 1'b1;
          AP_SUPER:   permFault = !supMode;
          AP_USER_RO: permFault = !supMode && cpuWrite;
          AP_FULL:    permFault = 1'b0;
          default:    permFault = 1'b1;
        endcase
      end
      // No access or reserved
      default: begin
        domainFault = 1'b1;
      end
    endcase
  end

  // Priority: alignment, domain, permission
  always_comb begin
    checkFault = 1'b0;
    checkCode  = NO_FAULT;
    if (misaligned) begin
      // Needs no translation
      checkFault = 1'b1;
      checkCode  = ALIGN;
    end else if (hit && domainFault) begin
      checkFault = 1'b1;
      checkCode  = hitEntry.isSection ? SECT_DOMAIN : PAGE_DOMAIN;
    end else if (hit && permFault) begin
      checkFault = 1'b1;
      checkCode  = hitEntry.isSection ? SECT_PERM : PAGE_PERM;
    end
  end

endmodule

`default_nettype wire

/* hdl/faultRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module faultRegs (
  input  logic             clk,
  input  logic             rst,
  input  logic             abortPulse,
  input  mmuPkg::faultCode abortCode,
  input  logic [3:0]       abortDomain,
  input  logic [31:0]      cpuAddr,
  output logic [31:0]      fsr,
  output logic [31:0]      far
);

  // Only the low byte of the FSR is ever written
  logic [7:0]  fsrLow;
  logic [31:0] farReg;

  // Capture on the abort cycle, readable the cycle after
  always_ff @(posedge clk) begin
    if (rst) begin
      fsrLow <= '0;
      farReg <= '0;
    end else if (abortPulse) begin
      // Domain in 7:4, status in 3:0
      fsrLow <= {abortDomain, abortCode};
      // Faulting virtual address
      farReg <= cpuAddr;
    end
  end

  // Upper FSR bits read as zero
  assign fsr = {24'b0, fsrLow};
  assign far = farReg;

endmodule

`default_nettype wire

/* hdl/mmu.sv */
`timescale 1ns/1ps
`include "mmu_consts.svh"
`default_nettype none

module mmu (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] control,
  input  logic [31:0] domainAccess,
  input  logic [17:0] tBase,
  input  logic        tlbFlush,
  input  logic        cpuReq,
  input  logic        cpuWrite,
  input  logic [31:0] cpuAddr,
  input  logic        wordAccess,
  input  logic        supMode,
  input  logic        dataAccess,
  input  logic        busReady,
  input  logic [31:0] busRData,
  output logic        cpuReady,
  output logic        busReq,
  output logic        busWrite,
  output logic [31:0] busAddr,
  output logic        prefetchAbort,
  output logic        dataAbort,
  output logic [31:0] fsr,
  output logic [31:0] far
);

  import mmuPkg::*;

  localparam int SECT_OFF = 32 - `MMU_SECT_INDEX_BITS;
  localparam int FRAME_LO = 20 - `MMU_SECT_INDEX_BITS;

  logic        enable;
  logic        hit;
  tlbEntry     hitEntry;
  logic        checkFault;
  faultCode    checkCode;
  logic        walkActive;
  logic [31:0] walkAddr;
  logic        tlbWe;
  tlbEntry     tlbFillEntry;
  logic        abortPulse;
  faultCode    abortCode;
  logic [3:0]  abortDomain;
  logic [31:0] physAddr;

  // Translation on when control[0] is set
  assign enable = control[0];

  tlbArray #(.ENTRIES(`MMU_TLB_ENTRIES)) tlb0 (
    .clk      (clk),
    .rst      (rst),
    .flush    (tlbFlush),
    .we       (tlbWe),
    .fillEntry(tlbFillEntry),
    .virtAddr (cpuAddr),
    .hit      (hit),
    .hitEntry (hitEntry)
  );

  accessCheck check0 (
    .cpuAddr     (cpuAddr[1:0]),
    .wordAccess  (wordAccess),
    .supMode     (supMode),
    .cpuWrite    (cpuWrite),
    .hit         (hit),
    .hitEntry    (hitEntry),
    .domainAccess(domainAccess),
    .checkFault  (checkFault),
    .checkCode   (checkCode)
  );

  tableWalk walk0 (
    .clk          (clk),
    .rst          (rst),
    .enable       (enable),
    .cpuReq       (cpuReq),
    .cpuAddr      (cpuAddr),
    .dataAccess   (dataAccess),
    .tBase        (tBase),
    .hit          (hit),
    .checkFault   (checkFault),
    .checkCode    (checkCode),
    .busReady     (busReady),
    .busRData     (busRData),
    .walkActive   (walkActive),
    .walkAddr     (walkAddr),
    .tlbWe        (tlbWe),
    .tlbFillEntry (tlbFillEntry),
    .abortPulse   (abortPulse),
    .abortCode    (abortCode),
    .prefetchAbort(prefetchAbort),
    .dataAbort    (dataAbort)
  );

  // Hit faults carry the entry domain, walk faults the descriptor domain
  assign abortDomain = hit ? hitEntry.domain : tlbFillEntry.domain;

  faultRegs fault0 (
    .clk        (clk),
    .rst        (rst),
    .abortPulse (abortPulse),
    .abortCode  (abortCode),
    .abortDomain(abortDomain),
    .cpuAddr    (cpuAddr),
    .fsr        (fsr),
    .far        (far)
  );

  // Section keeps 20 offset bits, small page 12
  assign physAddr = hitEntry.isSection ?
    {hitEntry.physFrame[19:FRAME_LO], cpuAddr[SECT_OFF-1:0]} :
    {hitEntry.physFrame, cpuAddr[`MMU_PAGE_OFFSET_BITS-1:0]};

  // Bus mux: bypass, walker, abort, translated CPU
  always_comb begin
    busReq   = 1'b0;
    busWrite = 1'b0;
    busAddr  = cpuAddr;
    cpuReady = 1'b0;
    if (!enable) begin
      busReq   = cpuReq;
      busWrite = cpuWrite;
      cpuReady = busReady;
    end else if (walkActive) begin
      // Descriptor reads only
      busReq  = 1'b1;
      busAddr = walkAddr;
    end else if (abortPulse) begin
      // Faulted access ends with no bus traffic
      cpuReady = 1'b1;
    end else if (hit) begin
      busReq   = cpuReq;
      busWrite = cpuWrite;
      busAddr  = physAddr;
      cpuReady = busReady;
    end
  end

endmodule

`default_nettype wire

/* hdl/mmuPkg.sv */
`default_nettype none

package mmuPkg;

  // Fault status codes
  // Listed from highest to lowest priority
  typedef enum logic [3:0] {
    NO_FAULT    = 4'b0000,
    ALIGN       = 4'b0001,
    SECT_TRANS  = 4'b0101,
    PAGE_TRANS  = 4'b0111,
    SECT_DOMAIN = 4'b1001,
    PAGE_DOMAIN = 4'b1011,
    SECT_PERM   = 4'b1101,
    PAGE_PERM   = 4'b1111
  } faultCode;

  // Access permission field
  // S and R control bits are taken as zero
  typedef enum logic [1:0] {
    AP_NONE    = 2'b00,
    AP_SUPER   = 2'b01,
    AP_USER_RO = 2'b10,
    AP_FULL    = 2'b11
  } apType;

  // One cached translation
  // Sections only use virtTag[19:8]
  typedef struct packed {
    logic        valid;
    logic        isSection;
    logic [19:0] virtTag;
    logic [19:0] physFrame;
    logic [3:0]  domain;
    apType       ap;
  } tlbEntry;

endpackage

`default_nettype wire

/* hdl/mmu_consts.svh */
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// TLB depth
`define MMU_TLB_ENTRIES 16

// Virtual address split
// Section index sits in bits 31:20
`define MMU_SECT_INDEX_BITS 12
// Coarse table index sits in bits 19:12
`define MMU_PAGE_INDEX_BITS 8
// Small page offset
`define MMU_PAGE_OFFSET_BITS 12

// First-level descriptor type, bits 1:0
`define MMU_L1_TYPE_FAULT 2'b00
`define MMU_L1_TYPE_COARSE 2'b01
`define MMU_L1_TYPE_SECTION 2'b10

// Second-level descriptor type, bits 1:0
`define MMU_L2_TYPE_SMALL 2'b10

`endif

/* hdl/tableWalk.sv */
`timescale 1ns/1ps
`include "mmu_consts.svh"
`default_nettype none

module tableWalk (
  input  logic             clk,
  input  logic             rst,
  input  logic             enable,
  input  logic             cpuReq,
  input  logic [31:0]      cpuAddr,
  input  logic             dataAccess,
  input  logic [17:0]      tBase,
  input  logic             hit,
  input  logic             checkFault,
  input  mmuPkg::faultCode checkCode,
  input  logic             busReady,
  input  logic [31:0]      busRData,
  output logic             walkActive,
  output logic [31:0]      walkAddr,
  output logic             tlbWe,
  output mmuPkg::tlbEntry  tlbFillEntry,
  output logic             abortPulse,
  output mmuPkg::faultCode abortCode,
  output logic             prefetchAbort,
  output logic             dataAbort
);

  import mmuPkg::*;

  localparam int SECT_LO = 32 - `MMU_SECT_INDEX_BITS;
  localparam int PAGE_LO = 20 - `MMU_PAGE_INDEX_BITS;

  typedef enum logic [2:0] {
    IDLE,
    L1_FETCH,
    L2_FETCH,
    FILL,
    ABORT
  } walkState;

  walkState    state;
  faultCode    walkCode;
  tlbEntry     fillEntry;
  // Coarse table base from the first-level descriptor
  logic [21:0] coarseBase;
  logic [1:0]  descType;
  logic        checkAbort;
  logic        startWalk;

  assign descType = busRData[1:0];

  // Check faults abort straight from idle, no walk
  assign checkAbort = (state == IDLE) && enable && cpuReq && checkFault;
  // Clean miss starts the walk
  assign startWalk = (state == IDLE) && enable && cpuReq && !hit && !checkFault;

  // Walk FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      walkCode <= NO_FAULT;
    end else begin
      case (state)
        IDLE: begin
          if (startWalk) begin
            state <= L1_FETCH;
          end
        end
        // Held here until the bus answers
        L1_FETCH: begin
          if (busReady) begin
            if (descType == `MMU_L1_TYPE_SECTION) begin
              state <= FILL;
            end else if (descType == `MMU_L1_TYPE_COARSE) begin
              state <= L2_FETCH;
            end else begin
              // Fault and fine descriptors both end the walk
              state    <= ABORT;
              walkCode <= SECT_TRANS;
            end
          end
        end
        L2_FETCH: begin
          if (busReady) begin
            if (descType == `MMU_L2_TYPE_SMALL) begin
              state <= FILL;
            end else begin
              state    <= ABORT;
              walkCode <= PAGE_TRANS;
            end
          end
        end
        // One write cycle, then the CPU access looks up again
        FILL: state <= IDLE;
        ABORT: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Descriptor capture
  always_ff @(posedge clk) begin
    if (state == L1_FETCH && busReady) begin
      coarseBase          <= busRData[31:10];
      fillEntry.valid     <= 1'b1;
      fillEntry.isSection <= (descType == `MMU_L1_TYPE_SECTION);
      fillEntry.virtTag   <= cpuAddr[31:12];
      // Section base in 31:20, low frame bits unused
      fillEntry.physFrame <= {busRData[31:20], 8'b0};
      fillEntry.domain    <= busRData[8:5];
      fillEntry.ap        <= apType'(busRData[11:10]);
    end
    // Small page keeps the domain of its first-level entry
    if (state == L2_FETCH && busReady) begin
      fillEntry.physFrame <= busRData[31:12];
      // AP0 stands for all four subpages
      fillEntry.ap        <= apType'(busRData[5:4]);
    end
  end

  // Descriptor address
  always_comb begin
    if (state == L2_FETCH) begin
      walkAddr = {coarseBase, cpuAddr[19:PAGE_LO], 2'b00};
    end else begin
      walkAddr = {tBase, cpuAddr[31:SECT_LO], 2'b00};
    end
  end

  // Bus owned only in the fetch states
  assign walkActive   = (state == L1_FETCH) || (state == L2_FETCH);
  assign tlbWe        = (state == FILL);
  assign tlbFillEntry = fillEntry;

  // Abort comes from the check in idle or from the walk one cycle later
  assign abortPulse = checkAbort || (state == ABORT);
  assign abortCode  = (state == ABORT) ? walkCode : checkCode;

  // Instruction fetches report prefetch aborts
  assign prefetchAbort = abortPulse && !dataAccess;
  assign dataAbort     = abortPulse && dataAccess;

endmodule

`default_nettype wire

/* hdl/tlbArray.sv */
`timescale 1ns/1ps
`include "mmu_consts.svh"
`default_nettype none

module tlbArray #(
  parameter int ENTRIES = `MMU_TLB_ENTRIES
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            flush,
  input  logic            we,
  input  mmuPkg::tlbEntry fillEntry,
  input  logic [31:0]     virtAddr,
  output logic            hit,
  output mmuPkg::tlbEntry hitEntry
);

  import mmuPkg::*;

  localparam int PTR_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;
  localparam int SECT_LO = 20 - `MMU_SECT_INDEX_BITS;
  localparam int ADDR_SECT_LO = 32 - `MMU_SECT_INDEX_BITS;

  // Entry payloads, with the valid bits held in their own vector
  tlbEntry            entries [ENTRIES];
  logic [ENTRIES-1:0] validBits;
  logic [PTR_W-1:0]   victim;
  logic [ENTRIES-1:0] matchVec;

  // Valid bits and round-robin victim pointer
  always_ff @(posedge clk) begin
    if (rst) begin
      validBits <= '0;
      victim    <= '0;
    end else begin
      // Flush wins over a fill in the same cycle
      if (flush) begin
        validBits <= '0;
      end else if (we) begin
        validBits[victim] <= fillEntry.valid;
      end
      if (we) begin
        victim <= (victim == PTR_W'(ENTRIES - 1)) ? '0 : victim + 1'b1;
      end
    end
  end

  // Entry payload written at the victim slot
  always_ff @(posedge clk) begin
    if (we) begin
      entries[victim] <= fillEntry;
    end
  end

  // Per-entry compare
  // Sections match 12 tag bits, small pages all 20
  always_comb begin
    for (int i = 0; i < ENTRIES; i++) begin
      if (entries[i].isSection) begin
        matchVec[i] = validBits[i] &&
          (entries[i].virtTag[19:SECT_LO] == virtAddr[31:ADDR_SECT_LO]);
      end else begin
        matchVec[i] = validBits[i] && (entries[i].virtTag == virtAddr[31:12]);
      end
    end
  end

  // Lowest matching index drives the hit
  always_comb begin
    hit      = 1'b0;
    hitEntry = '0;
    for (int i = ENTRIES - 1; i >= 0; i--) begin
      if (matchVec[i]) begin
        hit      = 1'b1;
        hitEntry = entries[i];
      end
    end
    // Valid flag reflects the lookup itself
    hitEntry.valid = hit;
  end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Compile and run the MMU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f build.f --top-module mmuTb -o mmuSim

output="$(./obj_dir/mmuSim)"
echo "$output"

if grep -qx "TESTBENCH PASSED" <<< "$output"; then
  exit 0
else
  echo "Simulation did not report a pass"
  exit 1
fi
